//--- Bender.yml
package:
  name: mxu

sources:
  - hdl/mxu_cfg_pkg.sv
  - hdl/mxu_ctrl_pkg.sv
  - hdl/host_if.sv
  - hdl/control_unit.sv
  - hdl/mac_array.sv
  - hdl/mxu_top.sv
  - target: test
    files:
      - bench/tb_mxu_top.sv

//--- bench/tb_mxu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mxu_top import mxu_cfg_pkg::*, mxu_ctrl_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_addr_t    wb_adr;
    wb_data_t    wb_dat_w;
    wb_data_t    wb_dat_r;
    logic        wb_ack;
    act_t        in_data;
    logic        in_empty;
    logic        in_read;
    acc_t        out_data;
    logic        out_full;
    logic        out_write;
    logic        cs_start;
    logic        cs_ready;
    logic        cs_done;
    logic        cs_idle;

    // fifo models and bookkeeping
    act_t        in_q [$];
    act_t        sent_words [$];
    acc_t        out_q [$];
    weight_t     wmem_model [NUM_PAGES*PAGE_WEIGHTS];
    logic [31:0] data_rng;
    logic [31:0] full_rng;
    logic        full_rand;
    int          errors;
    int          checks;
    int          tests;
    int          test_err_base;
    int          ready_count;
    int          ready_base;
    int          pop_count;
    string       cur_test;

    mxu_top mxu_top_inst (
        .clk, .reset,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .in_data, .in_empty, .in_read,
        .out_data, .out_full, .out_write,
        .cs_start, .cs_ready, .cs_done, .cs_idle
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // hard stop if a wait loop is ever missed
    initial begin
        #300000;
        $display("simulation watchdog expired before the tests ended");
        $display("Test failed");
        $finish;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // upper halves only, low lcg bits cycle fast
    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        data_rng = lcg_step(data_rng);
        hi = data_rng[31:16];
        data_rng = lcg_step(data_rng);
        return {hi, data_rng[31:16]};
    endfunction

    // significant low bits by precision
    function automatic longint sign_ext(input act_t word, input precision_e prec);
        byte     b;
        shortint h;
        int      w;
        b = word[7:0];
        h = word[15:0];
        w = word;
        case (prec)
            int8:    return b;
            int16:   return h;
            int32:   return w;
            default: return 0;
        endcase
    endfunction

    // row major weights within the page
    function automatic acc_t ref_row(input precision_e prec, input int page,
                                     input int vec, input int row);
        longint sum;
        longint w;
        sum = 0;
        for (int c = 0; c < COLUMNS; c++) begin
            w = wmem_model[page * PAGE_WEIGHTS + row * COLUMNS + c];
            sum += w * sign_ext(sent_words[vec * COLUMNS + c], prec);
        end
        return sum;
    endfunction

    task automatic note_error(input string msg);
        errors++;
        $display("%s: %s", cur_test, msg);
    endtask

    task automatic check_acc(input acc_t expected, input acc_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", cur_test, expected, actual);
        end
    endtask

    task automatic check_word(input wb_data_t expected, input wb_data_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", cur_test, expected, actual);
        end
    endtask

    task automatic check_flag(input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %b actual %b", cur_test, expected, actual);
        end
    endtask

    //////////////////////////////
    // fifo models
    //////////////////////////////
    // pops and pushes on the edge the dut uses them
    always @(posedge clk) begin
        if (!reset) begin
            if (in_read) begin
                // every read strobe counts, empty or not
                pop_count++;
                if (in_empty || in_q.size() == 0) begin
                    note_error("input FIFO read while empty");
                end else begin
                    void'(in_q.pop_front());
                end
            end
            if (out_write) begin
                if (out_full) begin
                    note_error("output FIFO written while full");
                end
                out_q.push_back(out_data);
            end
            if (cs_ready) begin
                ready_count++;
            end
        end
    end

    // flags and head word change on the falling edge
    always @(negedge clk) begin
        in_empty = (in_q.size() == 0);
        in_data  = (in_q.size() > 0) ? in_q[0] : '0;
        full_rng = lcg_step(full_rng);
        out_full = full_rand ? full_rng[20] : 1'b0;
    end

    //////////////////////////////
    // bus and job tasks
    //////////////////////////////
    task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
        int n;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        n = 0;
        @(negedge clk);
        while (!wb_ack && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack) begin
            note_error($sformatf("no ack for write to %h", addr));
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
        int n;
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        n = 0;
        @(negedge clk);
        while (!wb_ack && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack) begin
            note_error($sformatf("no ack for read from %h", addr));
        end
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic push_vector(input logic neg_low_byte);
        act_t w;
        for (int c = 0; c < COLUMNS; c++) begin
            w = rand_word();
            if (neg_low_byte) begin
                w[7] = 1'b1;
            end
            in_q.push_back(w);
            sent_words.push_back(w);
        end
    endtask

    task automatic start_job();
        ready_base = ready_count;
        cs_start   = 1'b1;
    endtask

    // cs_start drops on the cycle cs_done shows
    task automatic finish_job(input int limit);
        int n;
        n = 0;
        while (!cs_done && n < limit) begin
            @(negedge clk);
            n++;
        end
        cs_start = 1'b0;
        if (!cs_done) begin
            note_error($sformatf("job not done within %0d cycles", limit));
        end else begin
            check_flag(1'b1, ready_count == ready_base + 1);
        end
    endtask

    task automatic check_results(input precision_e prec, input int page, input int nvec);
        acc_t got;
        check_word(wb_data_t'(ROWS * nvec), wb_data_t'(out_q.size()));
        for (int v = 0; v < nvec; v++) begin
            for (int r = 0; r < ROWS; r++) begin
                if (out_q.size() > 0) begin
                    got = out_q.pop_front();
                    check_acc(ref_row(prec, page, v, r), got);
                end
            end
        end
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        test_err_base = errors;
        out_q.delete();
        sent_words.delete();
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_err_base) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: %0d errors", cur_test, errors - test_err_base);
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic test_reset_state();
        wb_data_t rd;
        begin_test("reset_state");
        repeat (2) @(negedge clk);
        check_flag(1'b1, cs_idle);
        check_flag(1'b0, in_read);
        check_flag(1'b0, out_write);
        check_flag(1'b0, cs_ready);
        check_flag(1'b0, cs_done);
        wb_read(REG_STATUS, rd);
        check_word(32'h0000_0001, rd);
        end_test();
    endtask

    task automatic test_register_access();
        wb_data_t rd;
        wb_data_t d;
        int       idx;
        begin_test("register_access");
        wb_write(REG_CONFIG, 32'h0000_0009);
        wb_read(REG_CONFIG, rd);
        check_word(32'h0000_0009, rd);
        // upper bits are not stored
        wb_write(REG_CONFIG, 32'hffff_fff6);
        wb_read(REG_CONFIG, rd);
        check_word(32'h0000_0006, rd);
        // pages 0 and 2
        for (int p = 0; p < 4; p += 2) begin
            for (int k = 0; k < PAGE_WEIGHTS; k++) begin
                idx = p * PAGE_WEIGHTS + k;
                d = rand_word();
                wmem_model[idx] = d[15:0];
                wb_write(wb_addr_t'(WM_BASE + 4 * idx), d);
            end
        end
        for (int p = 0; p < 4; p += 2) begin
            for (int k = 0; k < PAGE_WEIGHTS; k++) begin
                idx = p * PAGE_WEIGHTS + k;
                wb_read(wb_addr_t'(WM_BASE + 4 * idx), rd);
                check_word({16'h0000, wmem_model[idx]}, rd);
            end
        end
        wb_read(wb_addr_t'('h0c), rd);
        check_word(32'h0, rd);
        wb_read(wb_addr_t'('h40), rd);
        check_word(32'h0, rd);
        end_test();
    endtask

    task automatic test_single_int16();
        wb_data_t rd;
        begin_test("single_int16");
        wb_write(REG_CONFIG, 32'h0000_0001);
        wb_write(REG_CTRL, 32'h0000_0001);
        push_vector(1'b0);
        start_job();
        finish_job(400);
        check_results(int16, 0, 1);
        wb_read(REG_STATUS, rd);
        check_word(32'h0000_0101, rd);
        end_test();
    endtask

    task automatic test_batch_int8();
        wb_data_t rd;
        begin_test("batch_int8");
        // int8, page 2
        wb_write(REG_CONFIG, 32'h0000_0008);
        wb_write(REG_CTRL, 32'h0000_0001);
        repeat (3) push_vector(1'b1);
        full_rand = 1'b1;
        start_job();
        finish_job(800);
        full_rand = 1'b0;
        check_results(int8, 2, 3);
        wb_read(REG_STATUS, rd);
        check_word(32'h0000_0301, rd);
        end_test();
    endtask

    task automatic test_int32_starved();
        int pop_base;
        begin_test("int32_starved");
        // int32, page 2
        wb_write(REG_CONFIG, 32'h0000_000a);
        wb_write(REG_CTRL, 32'h0000_0001);
        pop_base = pop_count;
        start_job();
        repeat (30) @(negedge clk);
        check_flag(1'b0, pop_count != pop_base);
        check_flag(1'b0, cs_idle);
        push_vector(1'b0);
        finish_job(400);
        check_results(int32, 2, 1);
        end_test();
    endtask

    task automatic test_disabled_and_none();
        int pop_base;
        begin_test("disabled_and_none");
        wb_write(REG_CTRL, 32'h0000_0000);
        ready_base = ready_count;
        cs_start = 1'b1;
        repeat (50) @(negedge clk);
        check_flag(1'b0, ready_count != ready_base);
        check_flag(1'b1, cs_idle);
        cs_start = 1'b0;
        // precision none
        wb_write(REG_CONFIG, 32'h0000_0003);
        wb_write(REG_CTRL, 32'h0000_0001);
        pop_base = pop_count;
        start_job();
        finish_job(50);
        repeat (4) @(negedge clk);
        check_word(32'h0, wb_data_t'(out_q.size()));
        check_flag(1'b0, pop_count != pop_base);
        end_test();
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial begin
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        in_data     = '0;
        in_empty    = 1'b1;
        out_full    = 1'b0;
        cs_start    = 1'b0;
        full_rand   = 1'b0;
        data_rng    = 32'd51644;
        full_rng    = 32'd51644;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        ready_count = 0;
        pop_count   = 0;
        cur_test    = "reset";
        repeat (8) @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_register_access();
        test_single_int16();
        test_batch_int8();
        test_int32_starved();
        test_disabled_and_none();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hdl/mxu_cfg_pkg.sv
hdl/mxu_ctrl_pkg.sv
hdl/host_if.sv
hdl/control_unit.sv
hdl/mac_array.sv
hdl/mxu_top.sv
bench/tb_mxu_top.sv

//--- hdl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import mxu_cfg_pkg::*, mxu_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  mxu_config_t cfg,
    // input fifo
    input  logic        in_empty,
    output logic        in_read,
    // output fifo
    input  logic        out_full,
    output logic        out_write,
    output acc_t        out_data,
    // host handshake
    input  logic        cs_start,
    output logic        cs_ready,
    output logic        cs_done,
    output logic        cs_idle,
    // weight memory
    output logic        wm_rd,
    output wm_addr_t    wm_addr,
    // array
    output array_ctrl_t actl,
    input  acc_t        row_result,
    output logic        vector_done
);

    cu_state_e  state;
    precision_e prec_q;
    lane_t      req_cnt;
    wm_addr_t   wt_cnt;
    lane_t      cmp_cnt;
    // rows captured and rows written
    lane_t      res_cnt;
    lane_t      sav_cnt;
    // compute strobes in the array pipeline
    logic [1:0] cmp_pipe;
    acc_t       res_buf [ROWS];
    logic       res_avail;

    //////////////////////////////
    // fifo strobes, no stall
    //////////////////////////////
    assign cs_idle     = (state == idle);
    assign cs_ready    = (state == start_p1);
    assign vector_done = (state == done);
    // pop in the same cycle the word is shown
    assign in_read     = (state == request_data) && !in_empty;
    // 12 reads, last get_data cycle only loads
    assign wm_rd       = (state == get_data) && (wt_cnt < wm_addr_t'(PAGE_WEIGHTS));
    assign wm_addr     = wt_cnt;
    assign res_avail   = (res_cnt > sav_cnt);
    assign out_write   = (state == save_to_fifo) && res_avail && !out_full;
    assign out_data    = res_buf[sav_cnt];

    // array control word
    always_comb begin
        actl              = '0;
        actl.precision    = prec_q;
        actl.load_act     = in_read;
        actl.act_lane     = req_cnt;
        // loads trail reads by one cycle
        actl.load_weight  = (state == get_data) && (wt_cnt != '0);
        actl.weight_index = wt_cnt - wm_addr_t'(1);
        actl.compute      = (state == compute);
        actl.row_sel      = cmp_cnt;
    end

    //////////////////////////////
    // fsm
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= power_up;
            prec_q   <= none;
            req_cnt  <= '0;
            wt_cnt   <= '0;
            cmp_cnt  <= '0;
            res_cnt  <= '0;
            sav_cnt  <= '0;
            cmp_pipe <= '0;
            cs_done  <= 1'b0;
        end else begin
            cs_done  <= 1'b0;
            // row result lands two cycles after compute
            cmp_pipe <= {cmp_pipe[0], actl.compute};
            if (cmp_pipe[1]) begin
                res_cnt <= res_cnt + lane_t'(1);
            end
            case (state)
                power_up: begin
                    state <= idle;
                end
                idle: begin
                    if (cs_start && cfg.enable) begin
                        state <= start_p1;
                    end
                end
                start_p1: begin
                    prec_q <= cfg.precision;
                    if (cfg.precision == none) begin
                        // nothing to compute
                        state   <= idle;
                        cs_done <= 1'b1;
                    end else begin
                        state <= request_data;
                    end
                end
                request_data: begin
                    // waits on empty
                    if (in_read) begin
                        if (req_cnt == lane_t'(COLUMNS - 1)) begin
                            req_cnt <= '0;
                            state   <= get_data;
                        end else begin
                            req_cnt <= req_cnt + lane_t'(1);
                        end
                    end
                end
                get_data: begin
                    if (wt_cnt == wm_addr_t'(PAGE_WEIGHTS)) begin
                        wt_cnt <= '0;
                        state  <= compute;
                    end else begin
                        wt_cnt <= wt_cnt + wm_addr_t'(1);
                    end
                end
                compute: begin
                    if (cmp_cnt == lane_t'(ROWS - 1)) begin
                        cmp_cnt <= '0;
                        state   <= save_to_fifo;
                    end else begin
                        cmp_cnt <= cmp_cnt + lane_t'(1);
                    end
                end
                save_to_fifo: begin
                    // stalls on full or on a row still in flight
                    if (out_write) begin
                        if (sav_cnt == lane_t'(ROWS - 1)) begin
                            state <= done;
                        end else begin
                            sav_cnt <= sav_cnt + lane_t'(1);
                        end
                    end
                end
                done: begin
                    res_cnt <= '0;
                    sav_cnt <= '0;
                    if (cs_start && !in_empty) begin
                        state <= request_data;
                    end else begin
                        state   <= idle;
                        cs_done <= 1'b1;
                    end
                end
                default: begin
                    state <= power_up;
                end
            endcase
        end
    end

    // result buffer, one slot per row
    always_ff @(posedge clk) begin
        if (cmp_pipe[1]) begin
            res_buf[res_cnt] <= row_result;
        end
    end

endmodule

`default_nettype wire

//--- hdl/host_if.sv
`timescale 1ns/1ps
`default_nettype none

module host_if import mxu_cfg_pkg::*, mxu_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // wishbone classic slave
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  wb_addr_t    wb_adr,
    input  wb_data_t    wb_dat_w,
    output wb_data_t    wb_dat_r,
    output logic        wb_ack,
    // configuration level
    output mxu_config_t cfg,
    // weight read port, page relative
    input  logic        wm_rd,
    input  wm_addr_t    wm_addr,
    output weight_t     wm_data,
    // status from the control unit
    input  logic        vector_done,
    input  logic        cs_idle
);

    // weight storage, page major
    weight_t   wmem [NUM_PAGES*PAGE_WEIGHTS];

    logic       access;
    logic       wm_hit;
    wb_addr_t   wm_offset;
    wm_index_t  host_index;
    wm_index_t  ctl_index;
    logic [7:0] vec_count;

    // new request only while ack is low
    assign access = wb_cyc && wb_stb && !wb_ack;

    // weight window decode
    assign wm_offset  = wb_adr - WM_BASE;
    assign wm_hit     = (wb_adr >= WM_BASE) && (wm_offset < wb_addr_t'(WM_BYTES));
    // word index, byte lanes ignored
    assign host_index = wm_offset[7:2];

    // control side index from held page
    assign ctl_index = wm_index_t'(cfg.page) * wm_index_t'(PAGE_WEIGHTS)
                     + wm_index_t'(wm_addr);

    //////////////////////////////
    // ack
    //////////////////////////////
    // high one cycle after the request, then low one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    //////////////////////////////
    // config and status regs
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.enable    <= 1'b0;
            cfg.precision <= none;
            cfg.page      <= '0;
            vec_count     <= '0;
        end else begin
            if (vector_done) begin
                vec_count <= vec_count + 8'd1;
            end
            if (access && wb_we) begin
                case (wb_adr)
                    REG_CTRL: begin
                        cfg.enable <= wb_dat_w[0];
                        // new batch, restart count
                        if (wb_dat_w[0]) begin
                            vec_count <= '0;
                        end
                    end
                    REG_CONFIG: begin
                        cfg.precision <= precision_e'(wb_dat_w[1:0]);
                        cfg.page      <= wb_dat_w[3:2];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // read mux, unmapped gives zero
    always_ff @(posedge clk) begin
        if (access && !wb_we) begin
            if (wm_hit) begin
                wb_dat_r <= {16'h0000, wmem[host_index]};
            end else begin
                case (wb_adr)
                    REG_CTRL:   wb_dat_r <= {31'b0, cfg.enable};
                    REG_CONFIG: wb_dat_r <= {28'b0, cfg.page, cfg.precision};
                    REG_STATUS: wb_dat_r <= {16'b0, vec_count, 7'b0, cs_idle};
                    default:    wb_dat_r <= '0;
                endcase
            end
        end
    end

    //////////////////////////////
    // weight memory
    //////////////////////////////
    // host write port, control read port
    always_ff @(posedge clk) begin
        if (access && wb_we && wm_hit) begin
            wmem[host_index] <= wb_dat_w[15:0];
        end
        // data the cycle after the strobe
        if (wm_rd) begin
            wm_data <= wmem[ctl_index];
        end
    end

endmodule

`default_nettype wire

//--- hdl/mac_array.sv
`timescale 1ns/1ps
`default_nettype none

module mac_array import mxu_cfg_pkg::*, mxu_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  array_ctrl_t actl,
    input  act_t        in_data,
    input  weight_t     wm_data,
    output acc_t        row_result
);

    // sign-extended activation per lane
    act_t    act_reg [COLUMNS];
    // row major, index row*COLUMNS + column
    weight_t w_reg [PAGE_WEIGHTS];
    prod_t   prod [COLUMNS];
    logic    prod_valid;
    act_t    act_ext;
    acc_t    row_sum;

    //////////////////////////////
    // operand load
    //////////////////////////////
    // low bits significant by precision
    always_comb begin
        case (actl.precision)
            int8:    act_ext = {{24{in_data[7]}}, in_data[7:0]};
            int16:   act_ext = {{16{in_data[15]}}, in_data[15:0]};
            int32:   act_ext = in_data;
            default: act_ext = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (actl.load_act) begin
            act_reg[actl.act_lane] <= act_ext;
        end
        if (actl.load_weight) begin
            w_reg[actl.weight_index] <= wm_data;
        end
    end

    //////////////////////////////
    // multiply stage
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (actl.compute) begin
            for (int c = 0; c < COLUMNS; c++) begin
                prod[c] <= $signed(act_reg[c]) * w_reg[actl.row_sel * COLUMNS + c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= actl.compute;
        end
    end

    //////////////////////////////
    // sum stage
    //////////////////////////////
    // products sign-extended to result width
    always_comb begin
        row_sum = '0;
        for (int c = 0; c < COLUMNS; c++) begin
            row_sum = row_sum + acc_t'(prod[c]);
        end
    end

    // holds until the next row arrives
    always_ff @(posedge clk) begin
        if (prod_valid) begin
            row_result <= row_sum;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mxu_cfg_pkg.sv
`default_nettype none

package mxu_cfg_pkg;

    //////////////////////////////
    // array shape
    //////////////////////////////
    localparam int ROWS = 3;
    localparam int COLUMNS = 4;
    localparam int NUM_PAGES = 4;
    // one weight per array cell
    localparam int PAGE_WEIGHTS = ROWS * COLUMNS;

    //////////////////////////////
    // data widths
    //////////////////////////////
    typedef logic [31:0] act_t;
    typedef logic signed [15:0] weight_t;
    // activation times weight
    typedef logic signed [47:0] prod_t;
    typedef logic signed [63:0] acc_t;

    // weight index inside a page, 0 to 11
    typedef logic [3:0] wm_addr_t;
    typedef logic [1:0] page_t;
    // flat index over all pages
    typedef logic [5:0] wm_index_t;
    // activation lane or row select
    typedef logic [1:0] lane_t;

    typedef enum logic [1:0] {
        int8  = 2'd0,
        int16 = 2'd1,
        int32 = 2'd2,
        none  = 2'd3
    } precision_e;

endpackage

`default_nettype wire

//--- hdl/mxu_ctrl_pkg.sv
`default_nettype none

package mxu_ctrl_pkg;
    import mxu_cfg_pkg::*;

    //////////////////////////////
    // host bus
    //////////////////////////////
    // byte address, 9 bits to reach the top of the weight window
    localparam int WB_ADDR_W = 9;
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // register map
    localparam wb_addr_t REG_CTRL   = 'h00;
    localparam wb_addr_t REG_CONFIG = 'h04;
    // read only, idle and vector count
    localparam wb_addr_t REG_STATUS = 'h08;
    localparam wb_addr_t WM_BASE    = 'h80;
    // one 32-bit word per weight, low half kept
    localparam int WM_BYTES = 4 * NUM_PAGES * PAGE_WEIGHTS;

    //////////////////////////////
    // control structs
    //////////////////////////////
    typedef struct packed {
        logic       enable;
        precision_e precision;
        page_t      page;
    } mxu_config_t;

    typedef struct packed {
        logic       load_act;
        lane_t      act_lane;
        logic       load_weight;
        wm_addr_t   weight_index;
        logic       compute;
        lane_t      row_sel;
        precision_e precision;
    } array_ctrl_t;

    typedef enum logic [2:0] {
        power_up, idle, start_p1, request_data, get_data, compute, save_to_fifo, done
    } cu_state_e;

endpackage

`default_nettype wire

//--- hdl/mxu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mxu_top import mxu_cfg_pkg::*, mxu_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    // host bus
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack,
    // input fifo
    input  act_t     in_data,
    input  logic     in_empty,
    output logic     in_read,
    // output fifo
    output acc_t     out_data,
    input  logic     out_full,
    output logic     out_write,
    // host handshake
    input  logic     cs_start,
    output logic     cs_ready,
    output logic     cs_done,
    output logic     cs_idle
);

    mxu_config_t cfg;
    array_ctrl_t actl;
    logic        wm_rd;
    wm_addr_t    wm_addr;
    weight_t     wm_data;
    logic        vector_done;
    acc_t        row_result;

    //////////////////////////////
    // host side
    //////////////////////////////
    host_if host_if_inst (
        .clk, .reset,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .cfg, .wm_rd, .wm_addr, .wm_data,
        .vector_done, .cs_idle
    );

    // sequencing and output buffer
    control_unit control_unit_inst (
        .clk, .reset, .cfg,
        .in_empty, .in_read, .out_full, .out_write, .out_data,
        .cs_start, .cs_ready, .cs_done, .cs_idle,
        .wm_rd, .wm_addr, .actl, .row_result, .vector_done
    );

    // datapath
    mac_array mac_array_inst (
        .clk, .reset, .actl, .in_data, .wm_data, .row_result
    );

endmodule

`default_nettype wire
